//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_board_top
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = tests failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A crashed simulation counts as a failure
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; else echo "PASS"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/board_patterns.txt
// op addr data expect, all hex, op 0 ends the list
// 1 lock (data b0 pll, b1 ddr)  2 gpio_in  3 wait data cycles  4 write (expect pslverr)
// 5 read (expect pslverr)  6 pins (data dir<<12|out, expect sys_nrst)  7 end of group addr
6 000 00000000 0
1 000 00000001 0
3 000 00000014 0
6 000 00000000 0
5 000 00000001 0
1 000 00000003 0
3 000 00000010 0
6 000 00000000 0
3 000 00000001 0
6 000 00000000 1
5 000 00000007 0
5 008 00000001 0
7 001 00000000 0
4 100 ABCD5A3C 0
4 104 FFFFF0F5 0
6 000 00A3C0F5 1
5 100 00000A3C 0
5 104 000000F5 0
7 002 00000000 0
2 000 000005C3 0
3 000 00000002 0
5 108 000005C3 0
7 003 00000000 0
4 004 00000001 0
6 000 00A3C0F5 0
3 000 00000001 0
6 000 00000000 0
4 100 00000FFF 0
6 000 00000000 0
5 100 00000000 0
3 000 00000009 0
6 000 00000000 0
3 000 00000001 0
6 000 00000000 1
5 008 00000002 0
7 004 00000000 0
1 000 00000001 0
6 000 00000000 1
3 000 00000001 0
6 000 00000000 0
5 000 00000001 0
7 005 00000000 0
1 000 00000003 0
3 000 00000010 0
6 000 00000000 0
3 000 00000001 0
6 000 00000000 1
4 100 000003C3 0
4 200 00000000 1
4 204 00000001 1
5 200 00000000 1
6 000 003C3000 1
5 100 000003C3 0
5 008 00000003 0
7 006 00000000 0
0 000 00000000 0

//--- tb/tb_board_top.sv
// Testbench for the board control subsystem
// Replays the operations in the patterns file on the APB port and the
// reset and GPIO pins, and checks reads, pin outputs and the system reset
`timescale 1ns/1ps

module tb_board_top;
  import board_pkg::*;

  localparam int CLK_PERIOD      = 10;
  localparam int MAX_LINES       = 64;
  localparam int CYCLES_PER_LINE = 40;

  logic      i_clk;
  logic      i_rst_n;
  logic      i_psel;
  logic      i_penable;
  logic      i_pwrite;
  apb_addr_t i_paddr;
  apb_data_t i_pwdata;
  logic      o_pready;
  apb_data_t o_prdata;
  logic      o_pslverr;
  logic      i_pll_locked;
  logic      i_ddr_calib_done;
  gpio_vec_t i_gpio_in;
  gpio_vec_t o_gpio_out;
  gpio_vec_t o_gpio_dir;
  logic      o_sys_nrst;

  // Four words per line: opcode, address, data, expected
  logic [31:0] pat_mem [0:4*MAX_LINES-1];
  int          cycle_limit   = 0;
  int          error_count   = 0;
  int          group_errors  = 0;
  int          groups_done   = 0;
  int          groups_failed = 0;
  apb_data_t   rd_data;
  logic        rd_err;

  board_top dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // Run limit scales with the number of pattern lines
  initial begin
    int cycle_count;
    cycle_count = 0;
    while (cycle_limit == 0 || cycle_count < cycle_limit) begin
      @(posedge i_clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", cycle_count);
    $display("tests failed");
    $finish;
  end

  task automatic report_mismatch(input string what, input apb_data_t got, input apb_data_t exp);
    $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    error_count++;
    group_errors++;
  endtask

  // One APB transfer with a zero-wait-state access cycle
  task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t data);
    @(posedge i_clk);
    i_psel    <= 1'b1;
    i_penable <= 1'b0;
    i_pwrite  <= write;
    i_paddr   <= addr;
    i_pwdata  <= data;
    // No response in the setup phase
    @(negedge i_clk);
    if (o_pready !== 1'b0) begin
      report_mismatch("setup pready", 32'(o_pready), 32'd0);
    end
    if (o_pslverr !== 1'b0) begin
      report_mismatch("setup pslverr", 32'(o_pslverr), 32'd0);
    end
    @(posedge i_clk);
    i_penable <= 1'b1;
    @(negedge i_clk);
    if (o_pready !== 1'b1) begin
      report_mismatch("access pready", 32'(o_pready), 32'd1);
    end
    rd_data = o_prdata;
    rd_err  = o_pslverr;
    // Transfer completes on this edge
    @(posedge i_clk);
    i_psel    <= 1'b0;
    i_penable <= 1'b0;
  endtask

  // Expected pins packed as dir in 23:12 and out in 11:0
  task automatic check_pins(input apb_data_t exp_pins, input logic exp_nrst);
    @(negedge i_clk);
    if (o_gpio_out !== exp_pins[11:0]) begin
      report_mismatch("o_gpio_out", 32'(o_gpio_out), 32'(exp_pins[11:0]));
    end
    if (o_gpio_dir !== exp_pins[23:12]) begin
      report_mismatch("o_gpio_dir", 32'(o_gpio_dir), 32'(exp_pins[23:12]));
    end
    if (o_sys_nrst !== exp_nrst) begin
      report_mismatch("o_sys_nrst", 32'(o_sys_nrst), 32'(exp_nrst));
    end
  endtask

  task automatic finish_group(input int group_id);
    groups_done++;
    if (group_errors == 0) begin
      $display("group %0d ok", group_id);
    end else begin
      $display("group %0d FAILED with %0d mismatches", group_id, group_errors);
      groups_failed++;
    end
    group_errors = 0;
  endtask

  initial begin
    int          idx;
    int          num_lines;
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;

    i_rst_n          = 1'b0;
    i_psel           = 1'b0;
    i_penable        = 1'b0;
    i_pwrite         = 1'b0;
    i_paddr          = '0;
    i_pwdata         = '0;
    i_pll_locked     = 1'b0;
    i_ddr_calib_done = 1'b0;
    i_gpio_in        = '0;

    for (idx = 0; idx < 4*MAX_LINES; idx++) begin
      pat_mem[idx] = '0;
    end
    $readmemh("tb/board_patterns.txt", pat_mem);
    // Opcode 0 ends the list
    num_lines = 0;
    while (num_lines < MAX_LINES && pat_mem[4*num_lines] != 32'd0) begin
      num_lines++;
    end
    if (num_lines == 0) begin
      $display("No pattern lines were loaded from tb/board_patterns.txt");
    end
    cycle_limit = (num_lines + 4) * CYCLES_PER_LINE;

    repeat (4) @(posedge i_clk);
    i_rst_n <= 1'b1;

    for (idx = 0; idx < num_lines; idx++) begin
      op   = pat_mem[4*idx];
      addr = pat_mem[4*idx+1];
      data = pat_mem[4*idx+2];
      exp  = pat_mem[4*idx+3];
      case (op)
        32'd1: begin
          @(posedge i_clk);
          i_pll_locked     <= data[0];
          i_ddr_calib_done <= data[1];
        end
        32'd2: begin
          @(posedge i_clk);
          i_gpio_in <= data[11:0];
        end
        32'd3: repeat (data) @(posedge i_clk);
        32'd4: begin
          apb_transfer(1'b1, addr[11:0], data);
          if (rd_err !== exp[0]) begin
            report_mismatch("write pslverr", 32'(rd_err), 32'(exp[0]));
          end
        end
        32'd5: begin
          apb_transfer(1'b0, addr[11:0], 32'd0);
          if (rd_data !== data) begin
            report_mismatch("read data", rd_data, data);
          end
          if (rd_err !== exp[0]) begin
            report_mismatch("read pslverr", 32'(rd_err), 32'(exp[0]));
          end
        end
        32'd6: check_pins(data, exp[0]);
        32'd7: finish_group(addr);
        default: begin
          $display("Unknown opcode %h on pattern line %0d", op, idx);
          error_count++;
        end
      endcase
    end

    $display("groups run %0d, groups with errors %0d, mismatches %0d",
             groups_done, groups_failed, error_count);
    if (error_count == 0 && groups_done > 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- verilog/apb_decoder.sv
// APB address decoder
// Routes each transfer to the PRCI or GPIO region by address bits 11:8
// and answers unmapped addresses with an error in the access cycle
`timescale 1ns/1ps
`include "board_consts.svh"

module apb_decoder (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_psel,
  input  logic                 i_penable,
  input  logic                 i_pwrite,
  input  board_pkg::apb_addr_t i_paddr,
  input  board_pkg::apb_data_t i_pwdata,
  output logic                 o_pready,
  output board_pkg::apb_data_t o_prdata,
  output logic                 o_pslverr,
  apb_if.requester             m_prci,
  apb_if.requester             m_gpio
);
  import board_pkg::*;

  localparam int        RGN_MSB   = `BOARD_ADDR_W - 1;
  localparam int        RGN_LSB   = `BOARD_OFS_W;
  localparam apb_addr_t PRCI_BASE = `BOARD_PRCI_BASE;
  localparam apb_addr_t GPIO_BASE = `BOARD_GPIO_BASE;

  logic hit_prci;
  logic hit_gpio;
  logic err_q;
  logic err_access;

  assign hit_prci = (i_paddr[RGN_MSB:RGN_LSB] == PRCI_BASE[RGN_MSB:RGN_LSB]);
  assign hit_gpio = (i_paddr[RGN_MSB:RGN_LSB] == GPIO_BASE[RGN_MSB:RGN_LSB]);

  // Request fan-out, only the addressed slave sees psel
  assign m_prci.psel    = i_psel & hit_prci;
  assign m_prci.penable = i_penable & hit_prci;
  assign m_prci.pwrite  = i_pwrite;
  assign m_prci.paddr   = i_paddr;
  assign m_prci.pwdata  = i_pwdata;

  assign m_gpio.psel    = i_psel & hit_gpio;
  assign m_gpio.penable = i_penable & hit_gpio;
  assign m_gpio.pwrite  = i_pwrite;
  assign m_gpio.paddr   = i_paddr;
  assign m_gpio.pwdata  = i_pwdata;

  // Unmapped setup phase arms the error for the following access cycle
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      err_q <= 1'b0;
    end else begin
      err_q <= i_psel & ~i_penable & ~hit_prci & ~hit_gpio;
    end
  end

  assign err_access = err_q & i_psel & i_penable;

  // Response mux, no added latency
  always_comb begin
    o_pready  = 1'b0;
    o_prdata  = '0;
    o_pslverr = 1'b0;
    if (hit_prci) begin
      o_pready  = m_prci.pready;
      o_prdata  = m_prci.prdata;
      o_pslverr = m_prci.pslverr;
    end else if (hit_gpio) begin
      o_pready  = m_gpio.pready;
      o_prdata  = m_gpio.prdata;
      o_pslverr = m_gpio.pslverr;
    end else begin
      // Decoder answers by itself, read data stays 0
      o_pready  = err_access;
      o_pslverr = err_access;
    end
  end

endmodule

//--- verilog/apb_gpio.sv
// 12-bit GPIO block
// Direction and output registers under the system reset, and a
// two-flop synchronizer for the input pins
`timescale 1ns/1ps
`include "board_consts.svh"

module apb_gpio (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_sys_nrst,
  input  board_pkg::gpio_vec_t i_gpio_in,
  output board_pkg::gpio_vec_t o_gpio_out,
  output board_pkg::gpio_vec_t o_gpio_dir,
  apb_if.completer             s_apb
);
  import board_pkg::*;

  localparam int PAD_W = `BOARD_DATA_W - `BOARD_GPIO_W;

  gpio_vec_t               dir_q;
  gpio_vec_t               out_q;
  gpio_vec_t               in_meta_q;
  gpio_vec_t               in_sync_q;
  logic                    wr_en;
  logic [`BOARD_OFS_W-1:0] ofs;

  assign ofs   = s_apb.paddr[`BOARD_OFS_W-1:0];
  assign wr_en = s_apb.psel & s_apb.penable & s_apb.pwrite;

  // Direction bit 1 drives the pin, 0 leaves it as an input
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      dir_q <= '0;
      out_q <= '0;
    end else if (!i_sys_nrst) begin
      // Held in reset with the rest of the system, writes are dropped
      dir_q <= '0;
      out_q <= '0;
    end else if (wr_en) begin
      case (ofs)
        `GPIO_DIR_OFS: dir_q <= s_apb.pwdata[`BOARD_GPIO_W-1:0];
        `GPIO_OUT_OFS: out_q <= s_apb.pwdata[`BOARD_GPIO_W-1:0];
        default: begin
          dir_q <= dir_q;
          out_q <= out_q;
        end
      endcase
    end
  end

  // Input pins are asynchronous to i_clk
  always_ff @(posedge i_clk) begin
    in_meta_q <= i_gpio_in;
    in_sync_q <= in_meta_q;
  end

  assign o_gpio_dir = dir_q;
  assign o_gpio_out = out_q;

  always_comb begin
    s_apb.prdata = '0;
    if (s_apb.psel && !s_apb.pwrite) begin
      case (ofs)
        `GPIO_DIR_OFS: s_apb.prdata = {{PAD_W{1'b0}}, dir_q};
        `GPIO_OUT_OFS: s_apb.prdata = {{PAD_W{1'b0}}, out_q};
        `GPIO_IN_OFS:  s_apb.prdata = {{PAD_W{1'b0}}, in_sync_q};
        default:       s_apb.prdata = '0;
      endcase
    end
  end

  // Transfers complete even while the system reset is active
  assign s_apb.pready  = s_apb.psel & s_apb.penable;
  assign s_apb.pslverr = 1'b0;

endmodule

//--- verilog/apb_if.sv
// APB bus between the address decoder and one register slave
// Request side comes from the decoder, response side from the slave
`timescale 1ns/1ps

interface apb_if;
  import board_pkg::*;

  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;

  // Decoder side
  modport requester (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready, pslverr
  );

  // Register slave side
  modport completer (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
  );

endinterface

//--- verilog/apb_prci.sv
// PLL and reset control block
// Holds the system reset until PLL lock and DDR calibration have been
// stable for a fixed delay; software can force a new reset sequence
`timescale 1ns/1ps
`include "board_consts.svh"

module apb_prci (
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  logic     i_pll_locked,
  input  logic     i_ddr_calib_done,
  output logic     o_sys_nrst,
  apb_if.completer s_apb
);
  import board_pkg::*;

  localparam int               CNT_W    = $clog2(`PRCI_RST_DELAY);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`PRCI_RST_DELAY - 1);

  prci_state_e             state_q;
  prci_state_e             state_d;
  logic [CNT_W-1:0]        cnt_q;
  logic                    sys_nrst_q;
  apb_data_t               rstcnt_q;
  logic                    ready;
  logic                    wr_en;
  logic                    soft_rst;
  logic [`BOARD_OFS_W-1:0] ofs;

  assign ready = i_pll_locked & i_ddr_calib_done;
  assign ofs   = s_apb.paddr[`BOARD_OFS_W-1:0];
  assign wr_en = s_apb.psel & s_apb.penable & s_apb.pwrite;

  // Soft reset request, CTRL bit 0
  assign soft_rst = wr_en & (ofs == `PRCI_CTRL_OFS) & s_apb.pwdata[0];

  always_comb begin
    state_d = state_q;
    if (soft_rst) begin
      state_d = PRCI_WAIT_LOCK;
    end else begin
      case (state_q)
        PRCI_WAIT_LOCK: begin
          if (ready) begin
            state_d = PRCI_COUNT;
          end
        end
        PRCI_COUNT: begin
          if (!ready) begin
            state_d = PRCI_WAIT_LOCK;
          end else if (cnt_q == CNT_LAST) begin
            state_d = PRCI_RUN;
          end
        end
        PRCI_RUN: begin
          // Any loss of lock or calibration drops the reset again
          if (!ready) begin
            state_d = PRCI_WAIT_LOCK;
          end
        end
        default: state_d = PRCI_WAIT_LOCK;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q    <= PRCI_WAIT_LOCK;
      cnt_q      <= '0;
      sys_nrst_q <= 1'b0;
      rstcnt_q   <= '0;
    end else begin
      state_q <= state_d;
      // Count only while the sequencer sits in the delay state
      if (state_q == PRCI_COUNT) begin
        cnt_q <= cnt_q + 1'b1;
      end else begin
        cnt_q <= '0;
      end
      // Registered from the next state so the reset output cannot glitch
      sys_nrst_q <= (state_d == PRCI_RUN);
      if (state_d == PRCI_RUN && state_q != PRCI_RUN) begin
        rstcnt_q <= rstcnt_q + 1'b1;
      end
    end
  end

  assign o_sys_nrst = sys_nrst_q;

  // Register reads
  always_comb begin
    s_apb.prdata = '0;
    if (s_apb.psel && !s_apb.pwrite) begin
      case (ofs)
        `PRCI_STATUS_OFS: s_apb.prdata = apb_data_t'({sys_nrst_q, i_ddr_calib_done, i_pll_locked});
        `PRCI_RSTCNT_OFS: s_apb.prdata = rstcnt_q;
        // CTRL is write-only and reads back 0
        default:          s_apb.prdata = '0;
      endcase
    end
  end

  // Zero wait states, never an error
  assign s_apb.pready  = s_apb.psel & s_apb.penable;
  assign s_apb.pslverr = 1'b0;

endmodule

//--- verilog/board_consts.svh
// Board control subsystem constants
// Bus widths, APB address map, register offsets and reset timing
`ifndef BOARD_CONSTS_SVH
`define BOARD_CONSTS_SVH

// Bus and pin widths
`define BOARD_ADDR_W     12
`define BOARD_DATA_W     32
`define BOARD_GPIO_W     12
// Low byte of the address is the register offset, bits above pick the region
`define BOARD_OFS_W      8

// Address map, 0x100 bytes per region
`define BOARD_PRCI_BASE  12'h000
`define BOARD_GPIO_BASE  12'h100

// PRCI registers
`define PRCI_STATUS_OFS  8'h00
`define PRCI_CTRL_OFS    8'h04
`define PRCI_RSTCNT_OFS  8'h08

// GPIO registers
`define GPIO_DIR_OFS     8'h00
`define GPIO_OUT_OFS     8'h04
`define GPIO_IN_OFS      8'h08

// Cycles with PLL lock and DDR calibration both good before reset release
`define PRCI_RST_DELAY   16

`endif

//--- verilog/board_pkg.sv
// Board control subsystem types
// Width-carrying vectors for the APB side and the GPIO pins,
// plus the state encoding of the reset sequencer
`include "board_consts.svh"

package board_pkg;

  // APB bus fields
  typedef logic [`BOARD_ADDR_W-1:0] apb_addr_t;
  typedef logic [`BOARD_DATA_W-1:0] apb_data_t;

  // One bit per GPIO pin
  typedef logic [`BOARD_GPIO_W-1:0] gpio_vec_t;

  // Reset sequencer states
  typedef enum logic [1:0] {
    PRCI_WAIT_LOCK = 2'd0,
    PRCI_COUNT     = 2'd1,
    PRCI_RUN       = 2'd2
  } prci_state_e;

endpackage

//--- verilog/board_top.sv
// Board control subsystem top level
// APB port into the decoder, with the reset controller and GPIO
// block behind it
`timescale 1ns/1ps

module board_top (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  // APB slave port
  input  logic                 i_psel,
  input  logic                 i_penable,
  input  logic                 i_pwrite,
  input  board_pkg::apb_addr_t i_paddr,
  input  board_pkg::apb_data_t i_pwdata,
  output logic                 o_pready,
  output board_pkg::apb_data_t o_prdata,
  output logic                 o_pslverr,
  // Reset sources
  input  logic                 i_pll_locked,
  input  logic                 i_ddr_calib_done,
  // GPIO pins
  input  board_pkg::gpio_vec_t i_gpio_in,
  output board_pkg::gpio_vec_t o_gpio_out,
  output board_pkg::gpio_vec_t o_gpio_dir,
  output logic                 o_sys_nrst
);

  logic sys_nrst;

  apb_if prci_apb ();
  apb_if gpio_apb ();

  apb_decoder u_decoder (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .o_pready  (o_pready),
    .o_prdata  (o_prdata),
    .o_pslverr (o_pslverr),
    .m_prci    (prci_apb.requester),
    .m_gpio    (gpio_apb.requester)
  );

  apb_prci u_prci (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_pll_locked     (i_pll_locked),
    .i_ddr_calib_done (i_ddr_calib_done),
    .o_sys_nrst       (sys_nrst),
    .s_apb            (prci_apb.completer)
  );

  // GPIO sits under the system reset from the PRCI
  apb_gpio u_gpio (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_sys_nrst (sys_nrst),
    .i_gpio_in  (i_gpio_in),
    .o_gpio_out (o_gpio_out),
    .o_gpio_dir (o_gpio_dir),
    .s_apb      (gpio_apb.completer)
  );

  assign o_sys_nrst = sys_nrst;

endmodule

//--- vlog.f
+incdir+verilog
verilog/board_pkg.sv
verilog/apb_if.sv
verilog/apb_decoder.sv
verilog/apb_prci.sv
verilog/apb_gpio.sv
verilog/board_top.sv
tb/tb_board_top.sv
